/* src/arb_pkg.sv */
//----------------------------------------------------------
// Arbitration subsystem package
// Holds the mode and register offset encodings and the APB
// widths and field positions shared by the RTL blocks
//----------------------------------------------------------

package arb_pkg;

  //----------------------------------------------------------
  // Bus widths
  //----------------------------------------------------------

  localparam int APB_AW = 12;
  localparam int APB_DW = 32;

  // Word offset sits in address bits 9:2
  localparam int REG_OFF_LSB = 2;
  localparam int REG_OFF_W   = 8;

  //----------------------------------------------------------
  // Register field positions
  //----------------------------------------------------------

  localparam int MODE_LSB       = 0;
  localparam int CREDIT_EN_BIT  = 4;
  localparam int CREDIT_IDX_LSB = 8;

  // Arbitration mode, the unused code 3 behaves as round robin
  typedef enum logic [1:0] {
    mode_strict = 2'd0,
    mode_rotate = 2'd1,
    mode_rr     = 2'd2
  } arb_mode_e;

  // APB word offsets, grant counter i lives at base plus i
  typedef enum logic [7:0] {
    reg_ctrl           = 8'd0,
    reg_credit_load    = 8'd1,
    reg_stats_clear    = 8'd2,
    reg_status         = 8'd3,
    reg_grant_cnt_base = 8'd16
  } arb_reg_e;

endpackage

/* src/rr_arbiter.sv */
//----------------------------------------------------------
// Three mode arbiter
// Strict, rotating or round robin priority over NUM_REQS
// level requests, with the priority index held in a register
//----------------------------------------------------------

`timescale 1ns/100ps

module rr_arbiter #(
  parameter int NUM_REQS = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  arb_pkg::arb_mode_e          mode,
  input  logic [NUM_REQS-1:0]         reqs,
  input  logic                        update,
  output logic                        winner_v,
  output logic [$clog2(NUM_REQS)-1:0] winner,
  output logic                        grant_taken
);

  import arb_pkg::*;

  localparam int IDX_W = $clog2(NUM_REQS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_REQS - 1);

  logic [IDX_W-1:0]    idx_q;
  logic [IDX_W-1:0]    idx_next;
  logic [IDX_W-1:0]    idx;
  logic [IDX_W-1:0]    idx_plus1;
  logic [IDX_W-1:0]    win_plus1;
  logic [IDX_W-1:0]    prienc;
  logic [IDX_W:0]      win_sum;
  logic [NUM_REQS-1:0] reqs_rot;

  // Strict mode always starts the search at requestor 0
  assign idx = (mode == mode_strict) ? '0 : idx_q;

  //----------------------------------------------------------
  // Rotate and encode
  //----------------------------------------------------------

  // Rotate right by the index, modulo NUM_REQS so that any
  // requestor count works and not just powers of two
  always_comb begin
    int pos;
    for (int i = 0; i < NUM_REQS; i++) begin
      pos = i + int'(idx);
      if (pos >= NUM_REQS) begin
        pos = pos - NUM_REQS;
      end
      reqs_rot[i] = reqs[pos];
    end
  end

  // Lowest set bit of the rotated vector wins, scanning down so the
  // last hit is the lowest index
  always_comb begin
    prienc = '0;
    for (int i = NUM_REQS - 1; i >= 0; i--) begin
      if (reqs_rot[i]) begin
        prienc = IDX_W'(i);
      end
    end
  end

  // Undo the rotation by adding the index back, with one wrap
  always_comb begin
    win_sum = {1'b0, prienc} + {1'b0, idx};
    if (win_sum >= (IDX_W + 1)'(NUM_REQS)) begin
      win_sum = win_sum - (IDX_W + 1)'(NUM_REQS);
    end
  end

  assign winner_v    = |reqs;
  assign winner      = winner_v ? win_sum[IDX_W-1:0] : '0;
  assign grant_taken = winner_v & update;

  //----------------------------------------------------------
  // Priority index
  //----------------------------------------------------------

  assign idx_plus1 = (idx_q == LAST_IDX) ? '0 : idx_q + IDX_W'(1);
  assign win_plus1 = (winner == LAST_IDX) ? '0 : winner + IDX_W'(1);

  // The index only moves on an accepted grant, so a held winner
  // under back-pressure keeps its place
  always_comb begin
    idx_next = idx_q;
    if (mode == mode_strict) begin
      idx_next = '0;
    end else if (grant_taken) begin
      if (mode == mode_rotate) begin
        idx_next = idx_plus1;
      end else begin
        // Round robin, and the spare code 3 as well
        idx_next = win_plus1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q <= '0;
    end else begin
      idx_q <= idx_next;
    end
  end

endmodule

/* src/req_credit_counter.sv */
//----------------------------------------------------------
// Request credit counters
// One credit counter per requestor, loaded by software and
// spent on accepted grants, masks requestors out of credit
//----------------------------------------------------------

`timescale 1ns/100ps

module req_credit_counter #(
  parameter int NUM_REQS = 4,
  parameter int CREDIT_W = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [NUM_REQS-1:0]         reqs,
  input  logic                        credit_en,
  input  logic                        credit_load,
  input  logic [$clog2(NUM_REQS)-1:0] credit_idx,
  input  logic [CREDIT_W-1:0]         credit_val,
  input  logic                        grant_taken,
  input  logic [$clog2(NUM_REQS)-1:0] gnt_idx,
  output logic [NUM_REQS-1:0]         reqs_elig
);

  localparam int IDX_W = $clog2(NUM_REQS);

  logic [CREDIT_W-1:0] credit_q [NUM_REQS];
  logic [NUM_REQS-1:0] has_credit;

  //----------------------------------------------------------
  // Counters
  //----------------------------------------------------------

  // A reload beats a spend on the same requestor in the same cycle.
  // The count floors at zero so a grant taken with credits off
  // cannot wrap an empty counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REQS; i++) begin
        credit_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_REQS; i++) begin
        if (credit_load && (credit_idx == IDX_W'(i))) begin
          credit_q[i] <= credit_val;
        end else if (grant_taken && (gnt_idx == IDX_W'(i)) && (credit_q[i] != '0)) begin
          credit_q[i] <= credit_q[i] - CREDIT_W'(1);
        end
      end
    end
  end

  //----------------------------------------------------------
  // Request masking
  //----------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_REQS; i++) begin
      has_credit[i] = (credit_q[i] != '0);
    end
  end

  // With credits off the raw requests pass straight to the arbiter
  assign reqs_elig = credit_en ? (reqs & has_credit) : reqs;

endmodule

/* src/grant_stats.sv */
//----------------------------------------------------------
// Grant statistics
// Saturating per-requestor counts of accepted grants, read
// over APB and cleared together by a software strobe
//----------------------------------------------------------

`timescale 1ns/100ps

module grant_stats #(
  parameter int NUM_REQS = 4,
  parameter int CNT_W    = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        grant_taken,
  input  logic [$clog2(NUM_REQS)-1:0] gnt_idx,
  input  logic                        stats_clear,
  output logic [NUM_REQS*CNT_W-1:0]   grant_cnt
);

  localparam int IDX_W = $clog2(NUM_REQS);

  logic [CNT_W-1:0] cnt_q [NUM_REQS];

  // Clear takes priority over a grant landing in the same cycle,
  // and a full counter simply stays at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REQS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_REQS; i++) begin
        if (stats_clear) begin
          cnt_q[i] <= '0;
        end else if (grant_taken && (gnt_idx == IDX_W'(i)) && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + CNT_W'(1);
        end
      end
    end
  end

  // Flatten for the register block, requestor 0 in the low bits
  always_comb begin
    for (int i = 0; i < NUM_REQS; i++) begin
      grant_cnt[i*CNT_W +: CNT_W] = cnt_q[i];
    end
  end

endmodule

/* src/arb_apb_regs.sv */
//----------------------------------------------------------
// Arbitration register block
// APB slave with zero wait states holding the mode and credit
// enable, issuing credit reload and clear strobes and
// returning status and grant counters
//----------------------------------------------------------

`timescale 1ns/100ps

module arb_apb_regs #(
  parameter int NUM_REQS = 4,
  parameter int CREDIT_W = 4,
  parameter int CNT_W    = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [arb_pkg::APB_AW-1:0]  paddr,
  input  logic [arb_pkg::APB_DW-1:0]  pwdata,
  output logic [arb_pkg::APB_DW-1:0]  prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  logic [NUM_REQS-1:0]         reqs,
  input  logic [NUM_REQS*CNT_W-1:0]   grant_cnt,
  output arb_pkg::arb_mode_e          mode,
  output logic                        credit_en,
  output logic                        credit_load,
  output logic [$clog2(NUM_REQS)-1:0] credit_idx,
  output logic [CREDIT_W-1:0]         credit_val,
  output logic                        stats_clear
);

  import arb_pkg::*;

  localparam int IDX_W = $clog2(NUM_REQS);

  logic                 access;
  logic                 wr_en;
  logic [REG_OFF_W-1:0] word_off;
  arb_reg_e             reg_sel;
  logic [7:0]           cred_req;
  logic                 addr_err;
  logic [APB_DW-1:0]    rdata;

  //----------------------------------------------------------
  // Access decode
  //----------------------------------------------------------

  // No wait states, so the access phase is always the last cycle
  assign access   = psel & penable;
  assign wr_en    = access & pwrite;
  assign pready   = 1'b1;
  assign word_off = paddr[REG_OFF_LSB +: REG_OFF_W];
  assign reg_sel  = arb_reg_e'(word_off);

  // Requestor field of a credit reload, checked at its full width
  assign cred_req = pwdata[CREDIT_IDX_LSB +: 8];

  // Read data and error flag for the addressed word.
  // Computed every cycle and only exposed during the access phase
  always_comb begin
    rdata    = '0;
    addr_err = 1'b0;
    case (reg_sel)
      reg_ctrl: begin
        rdata[MODE_LSB +: 2]  = mode;
        rdata[CREDIT_EN_BIT]  = credit_en;
      end
      reg_credit_load: begin
        // Write only, reads return zero
        if (pwrite && (cred_req >= 8'(NUM_REQS))) begin
          addr_err = 1'b1;
        end
      end
      reg_stats_clear: begin
        rdata = '0;
      end
      reg_status: begin
        rdata[NUM_REQS-1:0] = reqs;
        addr_err            = pwrite;
      end
      default: begin
        // Anything outside the counter window is unmapped
        addr_err = 1'b1;
        for (int i = 0; i < NUM_REQS; i++) begin
          if (word_off == REG_OFF_W'(int'(reg_grant_cnt_base) + i)) begin
            rdata[CNT_W-1:0] = grant_cnt[i*CNT_W +: CNT_W];
            addr_err         = pwrite;
          end
        end
      end
    endcase
  end

  assign prdata  = (access && !pwrite) ? rdata : '0;
  assign pslverr = access & addr_err;

  //----------------------------------------------------------
  // Control register
  //----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode      <= mode_strict;
      credit_en <= 1'b0;
    end else if (wr_en && (reg_sel == reg_ctrl)) begin
      mode      <= arb_mode_e'(pwdata[MODE_LSB +: 2]);
      credit_en <= pwdata[CREDIT_EN_BIT];
    end
  end

  //----------------------------------------------------------
  // Strobes
  //----------------------------------------------------------

  // Strobes follow the access phase directly, so the datapath
  // registers update on the same edge as the write
  assign credit_load = wr_en & (reg_sel == reg_credit_load) & ~addr_err;
  assign credit_idx  = pwdata[CREDIT_IDX_LSB +: IDX_W];
  assign credit_val  = pwdata[CREDIT_W-1:0];
  assign stats_clear = wr_en & (reg_sel == reg_stats_clear);

endmodule

/* src/arb_subsys_top.sv */
//----------------------------------------------------------
// Arbitration subsystem top level
// Joins the APB register block to the credit counters, the
// arbiter and the grant statistics
//----------------------------------------------------------

`timescale 1ns/100ps

module arb_subsys_top #(
  parameter int NUM_REQS = 4,
  parameter int CREDIT_W = 4,
  parameter int CNT_W    = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [arb_pkg::APB_AW-1:0]  paddr,
  input  logic [arb_pkg::APB_DW-1:0]  pwdata,
  output logic [arb_pkg::APB_DW-1:0]  prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  logic [NUM_REQS-1:0]         reqs,
  input  logic                        gnt_ack,
  output logic                        gnt_v,
  output logic [$clog2(NUM_REQS)-1:0] gnt_idx
);

  import arb_pkg::*;

  localparam int IDX_W = $clog2(NUM_REQS);

  // Control from the register block
  arb_mode_e                 mode;
  logic                      credit_en;
  logic                      credit_load;
  logic [IDX_W-1:0]          credit_idx;
  logic [CREDIT_W-1:0]       credit_val;
  logic                      stats_clear;

  // Datapath links
  logic [NUM_REQS-1:0]       reqs_elig;
  logic                      grant_taken;
  logic [NUM_REQS*CNT_W-1:0] grant_cnt;

  arb_apb_regs #(
    .NUM_REQS (NUM_REQS),
    .CREDIT_W (CREDIT_W),
    .CNT_W    (CNT_W)
  ) i_arb_apb_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .reqs        (reqs),
    .grant_cnt   (grant_cnt),
    .mode        (mode),
    .credit_en   (credit_en),
    .credit_load (credit_load),
    .credit_idx  (credit_idx),
    .credit_val  (credit_val),
    .stats_clear (stats_clear)
  );

  req_credit_counter #(
    .NUM_REQS (NUM_REQS),
    .CREDIT_W (CREDIT_W)
  ) i_req_credit_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqs        (reqs),
    .credit_en   (credit_en),
    .credit_load (credit_load),
    .credit_idx  (credit_idx),
    .credit_val  (credit_val),
    .grant_taken (grant_taken),
    .gnt_idx     (gnt_idx),
    .reqs_elig   (reqs_elig)
  );

  // The resource acknowledge is the arbiter's index update
  rr_arbiter #(
    .NUM_REQS (NUM_REQS)
  ) i_rr_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .reqs        (reqs_elig),
    .update      (gnt_ack),
    .winner_v    (gnt_v),
    .winner      (gnt_idx),
    .grant_taken (grant_taken)
  );

  grant_stats #(
    .NUM_REQS (NUM_REQS),
    .CNT_W    (CNT_W)
  ) i_grant_stats (
    .clk         (clk),
    .rst_n       (rst_n),
    .grant_taken (grant_taken),
    .gnt_idx     (gnt_idx),
    .stats_clear (stats_clear),
    .grant_cnt   (grant_cnt)
  );

endmodule

/* testbench/tb_arb_subsys.sv */
//----------------------------------------------------------
// Arbitration subsystem testbench
// Random requests and acknowledges checked every cycle against
// a reference model, plus directed credit and APB register tests
//----------------------------------------------------------

`timescale 1ns/100ps

module tb_arb_subsys;

  localparam int NUM_REQS = 4;
  localparam int CREDIT_W = 4;
  localparam int CNT_W    = 16;
  localparam int IDX_W    = $clog2(NUM_REQS);

  // The watchdog allows the cycle budget of the whole run plus 20 percent
  localparam int RESET_CYCLES    = 10;
  localparam int RAND_CYCLES     = 300;
  localparam int DIRECTED_CYCLES = 200;
  localparam int TEST_CYCLES     = RESET_CYCLES + 3 * RAND_CYCLES + DIRECTED_CYCLES;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES * 12 / 10;

  logic                clk;
  logic                rst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [11:0]         paddr;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic [NUM_REQS-1:0] reqs;
  logic                gnt_ack;
  logic                gnt_v;
  logic [IDX_W-1:0]    gnt_idx;

  integer seed;
  int     error_count = 0;
  string  cur_test = "reset";

  // Reference model state
  logic [1:0] m_mode = 2'd0;
  logic       m_credit_en = 1'b0;
  int         m_idx = 0;
  int         m_credit [NUM_REQS] = '{default: 0};
  int         m_cnt [NUM_REQS] = '{default: 0};
  // Grants the DUT actually handed out per requestor
  int         m_wins [NUM_REQS] = '{default: 0};

  arb_subsys_top #(
    .NUM_REQS (NUM_REQS),
    .CREDIT_W (CREDIT_W),
    .CNT_W    (CNT_W)
  ) i_arb_subsys_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .reqs    (reqs),
    .gnt_ack (gnt_ack),
    .gnt_v   (gnt_v),
    .gnt_idx (gnt_idx)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //----------------------------------------------------------
  // Helpers
  //----------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Inputs always change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // First eligible requestor at or after start with wrap around
  function automatic int pick_winner(input logic [NUM_REQS-1:0] elig, input int start);
    int j;
    bit found;
    found = 1'b0;
    pick_winner = 0;
    for (int k = 0; k < NUM_REQS; k++) begin
      j = (start + k) % NUM_REQS;
      if (!found && elig[j]) begin
        pick_winner = j;
        found = 1'b1;
      end
    end
  endfunction

  // One zero wait state APB transfer that samples data and error in the access phase
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    next_cycle();
    penable = 1'b1;
    #2;
    check_value("apb pready", 32'd1, pready);
    rdata = prdata;
    err   = pslverr;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] off, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, {2'b00, off, 2'b00}, wdata, rdata, err);
    check_value({cur_test, " write pslverr"}, 32'd0, err);
  endtask

  task automatic run_random(input int cycles, input int ack_pct);
    repeat (cycles) begin
      reqs    = NUM_REQS'($random(seed));
      gnt_ack = ({$random(seed)} % 100) < ack_pct;
      next_cycle();
    end
  endtask

  //----------------------------------------------------------
  // Reference model
  //----------------------------------------------------------

  // Samples 3 ns after each edge, just before the next one, and moves
  // its own state as the DUT will at that coming edge
  initial begin : reference_model
    logic [NUM_REQS-1:0] elig;
    logic                exp_v;
    logic                taken;
    int                  start;
    int                  win;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #3;
      start = (m_mode == 2'd0) ? 0 : m_idx;
      for (int i = 0; i < NUM_REQS; i++) begin
        elig[i] = reqs[i] & (!m_credit_en || (m_credit[i] != 0));
      end
      exp_v = |elig;
      win   = pick_winner(elig, start);
      check_value({cur_test, " gnt_v"}, exp_v, gnt_v);
      if (exp_v) begin
        check_value({cur_test, " gnt_idx"}, win, gnt_idx);
      end
      taken = exp_v & gnt_ack;
      // Strict pins the index, rotate steps it and round robin follows the winner
      if (m_mode == 2'd0) begin
        m_idx = 0;
      end else if (taken) begin
        m_idx = (m_mode == 2'd1) ? (m_idx + 1) % NUM_REQS : (win + 1) % NUM_REQS;
      end
      if (taken) begin
        if (m_credit[win] != 0) begin
          m_credit[win]--;
        end
        if (m_cnt[win] != (1 << CNT_W) - 1) begin
          m_cnt[win]++;
        end
      end
      if (gnt_v && gnt_ack) begin
        m_wins[gnt_idx]++;
      end
      // A register write landing on this edge overrides spend and count
      if (psel && penable && pwrite) begin
        if (paddr[9:2] == 8'd0) begin
          m_mode      = pwdata[1:0];
          m_credit_en = pwdata[4];
        end else if (paddr[9:2] == 8'd1 && pwdata[15:8] < NUM_REQS) begin
          m_credit[pwdata[15:8]] = pwdata[CREDIT_W-1:0];
        end else if (paddr[9:2] == 8'd2) begin
          m_cnt = '{default: 0};
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

  //----------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------

  initial begin : stimulus
    logic [31:0] rd;
    logic        err;
    int          cred [NUM_REQS];
    seed    = 32'h08f18d84;
    cred    = '{2, 0, 3, 1};
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    reqs    = '0;
    gnt_ack = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    cur_test = "strict";
    run_random(RAND_CYCLES, 70);

    cur_test = "rotate";
    reqs = '0;
    reg_write(8'd0, 32'h1);
    run_random(RAND_CYCLES, 70);

    // Passing through strict clears the index so round robin starts at 0
    cur_test = "round_robin";
    reqs    = '0;
    gnt_ack = 1'b0;
    reg_write(8'd0, 32'h0);
    reg_write(8'd0, 32'h2);
    reqs    = '1;
    gnt_ack = 1'b1;
    for (int k = 0; k < 8; k++) begin
      #2;
      check_value("rr sequence", k % NUM_REQS, gnt_idx);
      next_cycle();
    end
    // Eight grants wrap the order back to requestor 0, which stays the
    // winner for as long as the acknowledge is held low
    gnt_ack = 1'b0;
    repeat (3) begin
      #2;
      check_value("rr backpressure", 8 % NUM_REQS, gnt_idx);
      next_cycle();
    end
    run_random(RAND_CYCLES, 60);

    // Round robin with credits enabled and all requestors asking
    cur_test = "credits";
    reqs    = '0;
    gnt_ack = 1'b0;
    reg_write(8'd0, 32'h12);
    for (int i = 0; i < NUM_REQS; i++) begin
      reg_write(8'd1, (i << 8) | cred[i]);
    end
    m_wins  = '{default: 0};
    reqs    = '1;
    gnt_ack = 1'b1;
    repeat (12) next_cycle();
    for (int i = 0; i < NUM_REQS; i++) begin
      check_value("credit wins", cred[i], m_wins[i]);
    end
    #2;
    check_value("credits spent", 32'd0, gnt_v);
    next_cycle();
    reg_write(8'd1, 32'h102);
    m_wins = '{default: 0};
    #2;
    check_value("reload gnt_v", 32'd1, gnt_v);
    check_value("reload gnt_idx", 32'd1, gnt_idx);
    repeat (5) next_cycle();
    check_value("reload wins", 32'd2, m_wins[1]);
    check_value("masked wins", 32'd0, m_wins[0] + m_wins[2] + m_wins[3]);

    cur_test = "registers";
    reqs    = '0;
    gnt_ack = 1'b0;
    next_cycle();
    for (int i = 0; i < NUM_REQS; i++) begin
      apb_access(1'b0, 12'((16 + i) << 2), 32'h0, rd, err);
      check_value("grant count", m_cnt[i], rd);
      check_value("grant count pslverr", 32'd0, err);
    end
    reg_write(8'd2, 32'h1);
    for (int i = 0; i < NUM_REQS; i++) begin
      apb_access(1'b0, 12'((16 + i) << 2), 32'h0, rd, err);
      check_value("cleared count", 32'd0, rd);
    end
    apb_access(1'b0, 12'h000, 32'h0, rd, err);
    check_value("ctrl readback", 32'h12, rd);
    reg_write(8'd0, 32'h1);
    apb_access(1'b0, 12'h000, 32'h0, rd, err);
    check_value("mode readback", 32'h1, rd);
    reqs = 4'b1010;
    apb_access(1'b0, 12'h00c, 32'h0, rd, err);
    check_value("status readback", 32'ha, rd);
    reqs = '0;
    apb_access(1'b1, 12'h00c, 32'h5, rd, err);
    check_value("status write pslverr", 32'd1, err);
    apb_access(1'b0, 12'h020, 32'h0, rd, err);
    check_value("offset 8 pslverr", 32'd1, err);
    next_cycle();

    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* files.f */
src/arb_pkg.sv
src/rr_arbiter.sv
src/req_credit_counter.sv
src/grant_stats.sv
src/arb_apb_regs.sv
src/arb_subsys_top.sv
testbench/tb_arb_subsys.sv

/* Bender.yml */
# Arbitration subsystem with APB register block
package:
  name: arb_subsys

dependencies: {}

sources:
  # Shared package first
  - src/arb_pkg.sv
  # Datapath blocks
  - src/rr_arbiter.sv
  - src/req_credit_counter.sv
  - src/grant_stats.sv
  # Control block and top level
  - src/arb_apb_regs.sv
  - src/arb_subsys_top.sv

  # Testbench, top module tb_arb_subsys
  - target: test
    files:
      - testbench/tb_arb_subsys.sv
